// File: filelist.f
+incdir+tb
design/mem_ctrl_pkg.sv
design/as_sequencer.sv
design/bram_port_ctrl.sv
design/array_ctrl.sv
design/mem_ctrl.sv
tb/tb_mem_ctrl.sv

// File: run.sh
#!/bin/sh
# builds and runs the mem_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_mem_ctrl \
    -f filelist.f

./obj_dir/Vtb_mem_ctrl > sim.log 2>&1
cat sim.log

if grep -qF '** PASS **' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tb/tb_mem_ctrl_model.svh
`ifndef TB_MEM_CTRL_MODEL_SVH
`define TB_MEM_CTRL_MODEL_SVH

// beat/line model, one step per clock edge
mem_ctrl_pkg::beat_t model_beat;
mem_ctrl_pkg::line_t model_line;
logic                model_run;

task clear_model;
    model_beat <= '0;
    model_line <= '0;
    model_run  <= 1'b0;
endtask

task step_model(input logic clear, input logic load, input logic load_as);
    if (clear) begin
        model_beat <= '0;
        model_line <= '0;
    end else if (model_run) begin
        model_beat <= model_beat + 2'd1;
        // line moves on the last beat, wraps after the write-back
        if (model_beat == 2'd3) begin
            if (model_line == mem_ctrl_pkg::save_last_line) begin
                model_line <= '0;
            end else begin
                model_line <= model_line + 9'd1;
            end
        end
    end
    if (load) begin
        model_run <= load_as;
    end
endtask

function automatic mem_ctrl_pkg::addr_t hash_addr(input mem_ctrl_pkg::line_t line,
                                                  input mem_ctrl_pkg::beat_t beat);
    return {23'd0, line} * mem_ctrl_pkg::hash_line_step +
           {30'd0, beat} * mem_ctrl_pkg::a_stride;
endfunction

function automatic mem_ctrl_pkg::addr_t square_sp_addr(input mem_ctrl_pkg::line_t line,
                                                       input mem_ctrl_pkg::beat_t beat,
                                                       input mem_ctrl_pkg::block_t block);
    return {23'd0, line} * mem_ctrl_pkg::sp_line_step +
           {30'd0, beat} * mem_ctrl_pkg::se_stride +
           (block[0] ? mem_ctrl_pkg::se_half_offset : 32'd0);
endfunction

// start of the 512-word pair window of a block
function automatic mem_ctrl_pkg::addr_t block_region_base(input mem_ctrl_pkg::block_t block);
    return mem_ctrl_pkg::b_base + {23'd0, block[9:1]} * mem_ctrl_pkg::pair_step;
endfunction

function automatic mem_ctrl_pkg::addr_t save_read_addr(input mem_ctrl_pkg::block_t block,
                                                       input mem_ctrl_pkg::beat_t beat);
    mem_ctrl_pkg::beat_t row;
    row = 2'd2 - beat;
    return block_region_base(block) +
           (block[0] ? mem_ctrl_pkg::half_step : 32'd0) +
           {30'd0, row} * mem_ctrl_pkg::row_step;
endfunction

`endif

// File: tb/tb_mem_ctrl.sv
`timescale 1ns/100ps

module tb_mem_ctrl;

    logic                    clk;
    logic                    rst_n;
    mem_ctrl_pkg::mem_mode_e mem_mode;
    logic                    calc_init;
    logic                    hash_ready;
    mem_ctrl_pkg::word_t     bram_data_sp;
    mem_ctrl_pkg::word_t     bram_data_hash;
    mem_ctrl_pkg::addr_t     addr_hash;
    mem_ctrl_pkg::addr_t     addr_sp;
    mem_ctrl_pkg::addr_t     addr_sp_2;
    logic                    wen_sp_2;
    mem_ctrl_pkg::word_t     data_left;
    mem_ctrl_pkg::word_t     data_right;
    mem_ctrl_pkg::word_t     data_adder;
    logic                    systolic_enable;
    logic                    systolic_state;
    logic                    transposer_select;
    logic                    transposer_rst_sync;
    mem_ctrl_pkg::phase_e    phase;

    integer                  seed;
    int                      error_count;
    int                      timeout_count;
    int                      test_count;
    int                      failed_tests;
    mem_ctrl_pkg::phase_e    last_phase;
    mem_ctrl_pkg::block_t    tb_block;
    int                      wen_count;
    logic                    block_init_copy;
    mem_ctrl_pkg::addr_t     exp_addr_hash;
    mem_ctrl_pkg::addr_t     exp_addr_sp;
    mem_ctrl_pkg::addr_t     exp_save_addr;
    mem_ctrl_pkg::addr_t     region_lo;

    `include "tb_mem_ctrl_model.svh"

    mem_ctrl mem_ctrl_inst (
        .clk                 (clk),
        .rst_n               (rst_n),
        .mem_mode            (mem_mode),
        .calc_init           (calc_init),
        .hash_ready          (hash_ready),
        .bram_data_sp        (bram_data_sp),
        .bram_data_hash      (bram_data_hash),
        .addr_hash           (addr_hash),
        .addr_sp             (addr_sp),
        .addr_sp_2           (addr_sp_2),
        .wen_sp_2            (wen_sp_2),
        .data_left           (data_left),
        .data_right          (data_right),
        .data_adder          (data_adder),
        .systolic_enable     (systolic_enable),
        .systolic_state      (systolic_state),
        .transposer_select   (transposer_select),
        .transposer_rst_sync (transposer_rst_sync),
        .phase               (phase)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // first square cycle after a wait
    assign block_init_copy = (phase == mem_ctrl_pkg::as_square) &&
                             (last_phase == mem_ctrl_pkg::as_waithash);

    assign exp_addr_hash = hash_addr(model_line, model_beat);
    assign exp_addr_sp   = square_sp_addr(model_line, model_beat, tb_block);
    assign exp_save_addr = save_read_addr(tb_block, model_beat);
    assign region_lo     = block_region_base(tb_block);

    always @(posedge clk) begin
        bram_data_sp   <= {$random(seed), $random(seed)};
        bram_data_hash <= {$random(seed), $random(seed)};
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            clear_model();
            last_phase <= mem_ctrl_pkg::free;
            tb_block   <= '0;
            wen_count  <= 0;
        end else begin
            step_model(calc_init || block_init_copy, calc_init, mem_mode == mem_ctrl_pkg::as);
            last_phase <= phase;
            if (calc_init) begin
                tb_block <= '0;
            end else if (phase == mem_ctrl_pkg::as_waithash &&
                         last_phase == mem_ctrl_pkg::as_save) begin
                tb_block <= tb_block + 10'd1;
            end
            if (phase != mem_ctrl_pkg::as_save) begin
                wen_count <= 0;
            end else if (wen_sp_2) begin
                wen_count <= wen_count + 1;
            end
        end
    end

    task report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        error_count++;
    endtask

    stream_addr: assert property (@(negedge clk) disable iff (!rst_n)
        phase == mem_ctrl_pkg::as_square |->
            addr_hash == exp_addr_hash && addr_sp == exp_addr_sp)
        else report_error("streaming address differs from model");

    stream_data: assert property (@(negedge clk) disable iff (!rst_n)
        phase == mem_ctrl_pkg::as_square |->
            data_left == bram_data_hash && data_right == bram_data_sp)
        else report_error("array operands differ from RAM words");

    // one swap per line seen on beat 1
    select_toggle: assert property (@(negedge clk) disable iff (!rst_n)
        (phase == mem_ctrl_pkg::as_square && $past(phase) == mem_ctrl_pkg::as_square &&
         $past(phase, 2) == mem_ctrl_pkg::as_square) |->
            ((transposer_select != $past(transposer_select)) == (model_beat == 2'd1)))
        else report_error("transposer select not toggling once per line");

    save_data: assert property (@(negedge clk) disable iff (!rst_n)
        phase == mem_ctrl_pkg::as_save |-> data_adder == bram_data_sp && systolic_enable)
        else report_error("adder feed or array enable wrong in write-back");

    save_addr: assert property (@(negedge clk) disable iff (!rst_n)
        phase == mem_ctrl_pkg::as_save |->
            addr_sp == exp_save_addr && ((addr_sp_2 - addr_sp) & 32'd511) == 32'd256 &&
            addr_sp >= region_lo && addr_sp < region_lo + mem_ctrl_pkg::pair_step &&
            addr_sp_2 >= region_lo && addr_sp_2 < region_lo + mem_ctrl_pkg::pair_step)
        else report_error("write-back address outside the block region");

    save_wen_total: assert property (@(negedge clk) disable iff (!rst_n)
        (phase == mem_ctrl_pkg::as_waithash && $past(phase) == mem_ctrl_pkg::as_save) |->
            wen_count == 4)
        else report_error("write enable count in write-back is not 4");

    // array state drops one cycle after line 338 beat 3
    array_state: assert property (@(negedge clk) disable iff (!rst_n)
        (phase != mem_ctrl_pkg::free && $past(phase) == phase) |->
            systolic_state == (phase == mem_ctrl_pkg::as_square ||
                               (phase == mem_ctrl_pkg::as_save &&
                                model_line <= mem_ctrl_pkg::save_stop_line)))
        else report_error("systolic state wrong for the phase");

    wait_enable: assert property (@(negedge clk) disable iff (!rst_n)
        (phase == mem_ctrl_pkg::as_waithash && $past(phase) == mem_ctrl_pkg::as_waithash) |->
            !systolic_enable)
        else report_error("array enabled during hash wait");

    wait_hold: assert property (@(negedge clk) disable iff (!rst_n)
        ($past(phase) == mem_ctrl_pkg::as_waithash && !$past(hash_ready)) |->
            phase == mem_ctrl_pkg::as_waithash)
        else report_error("left hash wait without hash_ready");

    rst_sync_origin: assert property (@(negedge clk) disable iff (!rst_n)
        transposer_rst_sync |->
            $past(phase) == mem_ctrl_pkg::as_square &&
            $past(phase, 2) == mem_ctrl_pkg::as_waithash && !$past(transposer_rst_sync))
        else report_error("transposer sync reset outside block restart");

    halves: assert property (@(negedge clk) disable iff (!rst_n)
        phase == mem_ctrl_pkg::as_square |->
            (addr_sp >= mem_ctrl_pkg::se_half_offset) == tb_block[0])
        else report_error("secret half does not match block parity");

    task end_test(input string name, input int err_base, input int to_base);
        test_count++;
        if (error_count == err_base && timeout_count == to_base) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed, %0d errors", name, error_count - err_base);
        end
    endtask

    task pulse_calc_init(input mem_ctrl_pkg::mem_mode_e mode);
        @(posedge clk);
        mem_mode  <= mode;
        calc_init <= 1'b1;
        @(posedge clk);
        calc_init <= 1'b0;
        @(negedge clk);
    endtask

    task wait_for_phase(input mem_ctrl_pkg::phase_e target, input int limit);
        int cycles;
        cycles = 0;
        while (phase != target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (phase != target) begin
            $display("timeout: phase stayed %s, %s not reached within %0d cycles",
                     phase.name(), target.name(), limit);
            timeout_count++;
        end
    endtask

    task check_ignored_mode(input mem_ctrl_pkg::mem_mode_e mode);
        pulse_calc_init(mode);
        repeat (50) begin
            @(negedge clk);
            assert (phase == mem_ctrl_pkg::free && addr_hash == '0 && addr_sp == '0 &&
                    addr_sp_2 == '0)
                else report_error("sequencer left idle on a non-AS mode");
        end
    endtask

    // hash engine busy for a random time before the next block
    task release_hash;
        int hold;
        int cycles;
        int pulses;
        hold = 5 + int'(($random(seed) & 32'h7fffffff) % 36);
        repeat (hold) @(negedge clk);
        @(posedge clk);
        hash_ready <= 1'b1;
        @(negedge clk);
        cycles = 0;
        while (phase == mem_ctrl_pkg::as_waithash && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        hash_ready <= 1'b0;
        if (phase != mem_ctrl_pkg::as_square) begin
            $display("timeout: no return to as_square after hash_ready");
            timeout_count++;
        end else begin
            pulses = 0;
            repeat (6) begin
                @(negedge clk);
                if (transposer_rst_sync) begin
                    pulses++;
                end
            end
            assert (pulses == 1)
                else report_error("transposer sync reset pulse is not one cycle");
        end
    endtask

    initial begin
        int err_base;
        int to_base;
        seed           = 32'h5c64b3a9;
        error_count    = 0;
        timeout_count  = 0;
        test_count     = 0;
        failed_tests   = 0;
        rst_n          = 1'b0;
        mem_mode       = mem_ctrl_pkg::idle;
        calc_init      = 1'b0;
        hash_ready     = 1'b0;
        bram_data_sp   = '0;
        bram_data_hash = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        err_base = error_count;
        to_base  = timeout_count;
        assert (phase == mem_ctrl_pkg::free && !wen_sp_2 && !systolic_enable &&
                !systolic_state && transposer_select)
            else report_error("wrong values after reset");
        end_test("reset", err_base, to_base);

        err_base = error_count;
        check_ignored_mode(mem_ctrl_pkg::sa);
        check_ignored_mode(mem_ctrl_pkg::idle);
        end_test("ignored modes", err_base, to_base);

        err_base = error_count;
        pulse_calc_init(mem_ctrl_pkg::as);
        wait_for_phase(mem_ctrl_pkg::as_save, 2000);
        end_test("streaming block 0", err_base, to_base);

        err_base = error_count;
        to_base  = timeout_count;
        if (timeout_count == 0) begin
            wait_for_phase(mem_ctrl_pkg::as_waithash, 40);
        end
        end_test("write-back", err_base, to_base);

        err_base = error_count;
        to_base  = timeout_count;
        if (timeout_count == 0) begin
            release_hash();
        end
        end_test("hash wait", err_base, to_base);

        err_base = error_count;
        to_base  = timeout_count;
        if (timeout_count == 0) begin
            wait_for_phase(mem_ctrl_pkg::as_save, 2000);
            wait_for_phase(mem_ctrl_pkg::as_waithash, 40);
            release_hash();
            wait_for_phase(mem_ctrl_pkg::as_save, 2000);
        end
        end_test("alternating halves", err_base, to_base);

        $display("tests run %0d, failed %0d, errors %0d, timeouts %0d",
                 test_count, failed_tests, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: design/mem_ctrl.sv
`timescale 1ns/100ps

module mem_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_ctrl_pkg::mem_mode_e mem_mode,
    input  logic                    calc_init,
    input  logic                    hash_ready,
    input  mem_ctrl_pkg::word_t     bram_data_sp,
    input  mem_ctrl_pkg::word_t     bram_data_hash,
    output mem_ctrl_pkg::addr_t     addr_hash,
    output mem_ctrl_pkg::addr_t     addr_sp,
    output mem_ctrl_pkg::addr_t     addr_sp_2,
    output logic                    wen_sp_2,
    output mem_ctrl_pkg::word_t     data_left,
    output mem_ctrl_pkg::word_t     data_right,
    output mem_ctrl_pkg::word_t     data_adder,
    output logic                    systolic_enable,
    output logic                    systolic_state,
    output logic                    transposer_select,
    output logic                    transposer_rst_sync,
    output mem_ctrl_pkg::phase_e    phase
);

    mem_ctrl_pkg::seq_status_t status;

    as_sequencer as_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_mode   (mem_mode),
        .calc_init  (calc_init),
        .hash_ready (hash_ready),
        .status     (status)
    );

    bram_port_ctrl bram_port_ctrl_inst (
        .status         (status),
        .bram_data_sp   (bram_data_sp),
        .bram_data_hash (bram_data_hash),
        .addr_hash      (addr_hash),
        .addr_sp        (addr_sp),
        .addr_sp_2      (addr_sp_2),
        .wen_sp_2       (wen_sp_2),
        .data_left      (data_left),
        .data_right     (data_right),
        .data_adder     (data_adder)
    );

    array_ctrl array_ctrl_inst (
        .clk                 (clk),
        .rst_n               (rst_n),
        .calc_init           (calc_init),
        .status              (status),
        .systolic_enable     (systolic_enable),
        .systolic_state      (systolic_state),
        .transposer_select   (transposer_select),
        .transposer_rst_sync (transposer_rst_sync)
    );

    assign phase = status.phase;

endmodule

// File: design/array_ctrl.sv
`timescale 1ns/100ps

module array_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      calc_init,
    input  mem_ctrl_pkg::seq_status_t status,
    output logic                      systolic_enable,
    output logic                      systolic_state,
    output logic                      transposer_select,
    output logic                      transposer_rst_sync
);

    logic enable_point;
    logic stop_point;

    // first operands reach the array one beat into line 1
    assign enable_point = (status.line == mem_ctrl_pkg::enable_line) &&
                          (status.beat == mem_ctrl_pkg::beat_t'(1));
    assign stop_point   = (status.line == mem_ctrl_pkg::save_stop_line) &&
                          (status.beat == '1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            systolic_enable <= 1'b0;
        end else begin
            case (status.phase)
                mem_ctrl_pkg::as_square: begin
                    if (enable_point) begin
                        systolic_enable <= 1'b1;
                    end
                end
                mem_ctrl_pkg::as_save: begin
                    systolic_enable <= 1'b1;
                end
                mem_ctrl_pkg::as_waithash: begin
                    systolic_enable <= 1'b0;
                end
                default: begin
                    systolic_enable <= systolic_enable;
                end
            endcase
        end
    end

    // compute while streaming, drain late in write-back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            systolic_state <= 1'b0;
        end else begin
            case (status.phase)
                mem_ctrl_pkg::as_square: begin
                    if (status.prev_phase != mem_ctrl_pkg::as_square) begin
                        systolic_state <= 1'b1;
                    end
                end
                mem_ctrl_pkg::as_save: begin
                    if (stop_point) begin
                        systolic_state <= 1'b0;
                    end
                end
                default: begin
                    systolic_state <= systolic_state;
                end
            endcase
        end
    end

    // ping-pong half swaps once per line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            transposer_select <= 1'b1;
        end else if (calc_init || status.block_init) begin
            transposer_select <= 1'b1;
        end else if (status.beat == '0) begin
            transposer_select <= ~transposer_select;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            transposer_rst_sync <= 1'b0;
        end else begin
            transposer_rst_sync <= status.block_init;
        end
    end

endmodule

// File: design/bram_port_ctrl.sv
`timescale 1ns/100ps

module bram_port_ctrl (
    input  mem_ctrl_pkg::seq_status_t status,
    input  mem_ctrl_pkg::word_t       bram_data_sp,
    input  mem_ctrl_pkg::word_t       bram_data_hash,
    output mem_ctrl_pkg::addr_t       addr_hash,
    output mem_ctrl_pkg::addr_t       addr_sp,
    output mem_ctrl_pkg::addr_t       addr_sp_2,
    output logic                      wen_sp_2,
    output mem_ctrl_pkg::word_t       data_left,
    output mem_ctrl_pkg::word_t       data_right,
    output mem_ctrl_pkg::word_t       data_adder
);

    mem_ctrl_pkg::addr_t line_ext;
    mem_ctrl_pkg::addr_t beat_ext;
    mem_ctrl_pkg::addr_t se_half;
    mem_ctrl_pkg::addr_t sq_addr_hash;
    mem_ctrl_pkg::addr_t sq_addr_sp;
    mem_ctrl_pkg::addr_t pair_base;
    mem_ctrl_pkg::addr_t save_addr_rd;
    mem_ctrl_pkg::addr_t save_addr_wr;
    mem_ctrl_pkg::beat_t save_row;
    mem_ctrl_pkg::beat_t save_row_w;
    logic                save_wen;

    assign line_ext = mem_ctrl_pkg::addr_t'(status.line);
    assign beat_ext = mem_ctrl_pkg::addr_t'(status.beat);

    // odd blocks read the second secret half
    assign se_half = status.block[0] ? mem_ctrl_pkg::se_half_offset : '0;

    // streaming addresses, beat selects the 4-row group
    assign sq_addr_hash = line_ext * mem_ctrl_pkg::hash_line_step +
                          beat_ext * mem_ctrl_pkg::a_stride;
    assign sq_addr_sp   = line_ext * mem_ctrl_pkg::sp_line_step +
                          beat_ext * mem_ctrl_pkg::se_stride + se_half;

    // write-back rows, beat 0 hits row 2 and counts down
    assign save_row   = mem_ctrl_pkg::beat_t'(2) - status.beat;
    assign save_row_w = save_row + mem_ctrl_pkg::beat_t'(2);

    assign pair_base = mem_ctrl_pkg::b_base +
                       mem_ctrl_pkg::addr_t'(status.block >> 1) * mem_ctrl_pkg::pair_step +
                       (status.block[0] ? mem_ctrl_pkg::half_step : '0);

    assign save_addr_rd = pair_base +
                          mem_ctrl_pkg::addr_t'(save_row) * mem_ctrl_pkg::row_step;
    assign save_addr_wr = pair_base +
                          mem_ctrl_pkg::addr_t'(save_row_w) * mem_ctrl_pkg::row_step;

    // four write beats straddling the last two lines
    assign save_wen = ((status.line == mem_ctrl_pkg::save_wen_line) && (status.beat != '0)) ||
                      ((status.line == mem_ctrl_pkg::save_last_line) && (status.beat == '0));

    always_comb begin
        addr_hash  = '0;
        addr_sp    = '0;
        addr_sp_2  = '0;
        wen_sp_2   = 1'b0;
        data_left  = '0;
        data_right = '0;
        data_adder = '0;
        case (status.phase)
            mem_ctrl_pkg::as_square: begin
                addr_hash  = sq_addr_hash;
                addr_sp    = sq_addr_sp;
                data_left  = bram_data_hash;
                data_right = bram_data_sp;
            end
            mem_ctrl_pkg::as_save: begin
                // read partial sum, write back two rows further on
                addr_sp    = save_addr_rd;
                addr_sp_2  = save_addr_wr;
                wen_sp_2   = save_wen;
                data_adder = bram_data_sp;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: design/as_sequencer.sv
`timescale 1ns/100ps

module as_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mem_ctrl_pkg::mem_mode_e   mem_mode,
    input  logic                      calc_init,
    input  logic                      hash_ready,
    output mem_ctrl_pkg::seq_status_t status
);

    mem_ctrl_pkg::mem_mode_e mode;
    logic                    mode_run;
    mem_ctrl_pkg::phase_e    phase;
    mem_ctrl_pkg::phase_e    next_phase;
    mem_ctrl_pkg::phase_e    prev_phase;
    mem_ctrl_pkg::beat_t     beat;
    mem_ctrl_pkg::line_t     line;
    mem_ctrl_pkg::block_t    block;
    logic                    block_init;
    logic                    beat_last;
    logic                    save_done;

    assign beat_last = (beat == '1);

    // last write-back beat of the block
    assign save_done = (phase == mem_ctrl_pkg::as_save) &&
                       (line == mem_ctrl_pkg::save_last_line) && beat_last;

    // mode latch, streaming starts one cycle after the mode is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode     <= mem_ctrl_pkg::idle;
            mode_run <= 1'b0;
        end else begin
            if (calc_init) begin
                mode <= mem_mode;
            end
            mode_run <= (mode == mem_ctrl_pkg::as);
        end
    end

    always_comb begin
        case (phase)
            mem_ctrl_pkg::free: begin
                next_phase = mode_run ? mem_ctrl_pkg::as_square : mem_ctrl_pkg::free;
            end
            mem_ctrl_pkg::as_square: begin
                if (line == mem_ctrl_pkg::square_last_line) begin
                    next_phase = mem_ctrl_pkg::as_save;
                end else begin
                    next_phase = mem_ctrl_pkg::as_square;
                end
            end
            mem_ctrl_pkg::as_save: begin
                next_phase = save_done ? mem_ctrl_pkg::as_waithash : mem_ctrl_pkg::as_save;
            end
            mem_ctrl_pkg::as_waithash: begin
                // stall until the hash engine has the next A rows
                next_phase = hash_ready ? mem_ctrl_pkg::as_square : mem_ctrl_pkg::as_waithash;
            end
            default: begin
                next_phase = mem_ctrl_pkg::free;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= mem_ctrl_pkg::free;
            prev_phase <= mem_ctrl_pkg::free;
            block_init <= 1'b0;
        end else begin
            phase      <= next_phase;
            prev_phase <= phase;
            block_init <= (phase == mem_ctrl_pkg::as_waithash) &&
                          (next_phase == mem_ctrl_pkg::as_square);
        end
    end

    // beat runs free while in AS mode, wait phase included
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
        end else if (calc_init || block_init) begin
            beat <= '0;
        end else if (mode == mem_ctrl_pkg::as) begin
            beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line <= '0;
        end else if (calc_init || block_init) begin
            line <= '0;
        end else if (beat_last) begin
            if (line == mem_ctrl_pkg::save_last_line) begin
                line <= '0;
            end else begin
                line <= line + 1'b1;
            end
        end
    end

    // result block count, bit 0 picks the secret half
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block <= '0;
        end else if (calc_init) begin
            block <= '0;
        end else if (save_done) begin
            block <= block + 1'b1;
        end
    end

    assign status = '{
        phase:      phase,
        prev_phase: prev_phase,
        beat:       beat,
        line:       line,
        block:      block,
        block_init: block_init
    };

endmodule

// File: design/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

    // one 4-row beat group per beat
    localparam int beats_per_line = 4;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] word_t;
    typedef logic [$clog2(beats_per_line)-1:0] beat_t;
    typedef logic [8:0] line_t;
    typedef logic [9:0] block_t;

    typedef enum logic [2:0] {
        idle = 3'd0,
        as   = 3'd1,
        sa   = 3'd2,
        sb   = 3'd3,
        bs   = 3'd4
    } mem_mode_e;

    typedef enum logic [3:0] {
        free        = 4'd0,
        as_square   = 4'd1,
        as_save     = 4'd2,
        as_waithash = 4'd3
    } phase_e;

    // line marks of one result block
    localparam line_t enable_line      = 9'd1;
    localparam line_t square_last_line = 9'd336;
    localparam line_t save_stop_line   = 9'd338;
    localparam line_t save_wen_line    = 9'd339;
    localparam line_t save_last_line   = 9'd340;

    // matrix geometry in RAM words
    localparam addr_t a_stride       = 32'd1344 * 32'd16;
    localparam addr_t se_stride      = 32'd1344 * 32'd8;
    localparam addr_t se_half_offset = 32'd4 * se_stride;
    localparam addr_t b_base         = 32'd1344 * 32'd64;

    localparam addr_t hash_line_step = 32'd64;
    localparam addr_t sp_line_step   = 32'd32;

    // B region layout, two blocks share a pair window
    localparam addr_t pair_step = 32'd512;
    localparam addr_t half_step = 32'd64;
    localparam addr_t row_step  = 32'd128;

    typedef struct packed {
        phase_e phase;
        phase_e prev_phase;
        beat_t  beat;
        line_t  line;
        block_t block;
        logic   block_init;
    } seq_status_t;

endpackage
